//--- Bender.yml
package:
  name: cpu16

sources:
  - files:
      - rtl/cpuPkg.sv
      - rtl/loadReg.sv
      - rtl/registerFile.sv
      - rtl/alu.sv
      - rtl/programCounter.sv
      - rtl/cpuController.sv
      - rtl/cpu.sv
  - target: test
    files:
      - tb/cpuChecks_sva.sv
      - tb/cpuTb.sv

//--- build.f
rtl/cpuPkg.sv
rtl/loadReg.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/programCounter.sv
rtl/cpuController.sv
rtl/cpu.sv
tb/cpuChecks_sva.sv
tb/cpuTb.sv

//--- rtl/alu.sv
module alu import cpuPkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  result,
    output psr_t   flags
);

    localparam int msb = wordWidth - 1;

    logic [wordWidth:0] sum;
    logic [wordWidth:0] diff;
    word_t              shifted;
    logic               addOverflow;
    logic               subOverflow;

    // Destination operand is b, source operand is a
    assign sum  = {1'b0, b} + {1'b0, a};
    assign diff = {1'b0, b} - {1'b0, a};

    // Bit 4 of the amount turns the shift around
    assign shifted = a[4] ? (b >> a[3:0]) : (b << a[3:0]);

    assign addOverflow = (a[msb] == b[msb]) && (sum[msb] != b[msb]);
    assign subOverflow = (a[msb] != b[msb]) && (diff[msb] != b[msb]);

    ////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            extAdd:         result = sum[msb:0];
            extSub, extCmp: result = diff[msb:0];
            extAnd:         result = b & a;
            extOr:          result = b | a;
            extXor:         result = b ^ a;
            extMov:         result = a;
            extLsh:         result = shifted;
            default:        result = b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Status flags
    ////////////////////////////////////////////////////////////

    always_comb begin
        flags.carry = 1'b0;
        flags.flag  = 1'b0;
        case (op)
            extAdd: begin
                flags.carry = sum[wordWidth];
                flags.flag  = addOverflow;
            end
            extSub, extCmp: begin
                // Borrow out of the subtract
                flags.carry = diff[wordWidth];
                flags.flag  = subOverflow;
            end
            default: begin
                flags.carry = 1'b0;
                flags.flag  = 1'b0;
            end
        endcase

        // Unsigned b < a is the same as the borrow
        flags.low  = diff[wordWidth];
        flags.zero = (result == '0);

        // Compare reports signed b < a, corrected for overflow
        if (op == extCmp) begin
            flags.negative = diff[msb] ^ subOverflow;
        end else begin
            flags.negative = result[msb];
        end
    end

endmodule

//--- rtl/cpu.sv
module cpu import cpuPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  word_t      memData,
    input  logic       serialValid,
    input  word_t      serialRead,
    input  logic [7:0] gamePad,
    output word_t      memAddr,
    output logic       memWrite,
    output word_t      dataOut,
    output word_t      vgaStart,
    output word_t      vgaRow,
    output logic       serialWrite
);

    word_t   instr;
    psr_t    flags;
    psr_t    aluFlags;
    logic    regWrite;
    logic    regWriteSel;
    regIdx_t writeIdx;
    regIdx_t readIdxA;
    regIdx_t readIdxB;
    word_t   immediate;
    aluSrc_t aluSrc;
    aluOp_t  aluOp;
    logic    addrFromReg;
    logic    pcIncrement;
    logic    pcBranch;
    logic    pcJump;
    logic    irLoad;
    logic    psrLoad;
    logic    vgaStartLoad;
    logic    vgaRowLoad;
    ioExt_t  inputSel;
    word_t   readA;
    word_t   readB;
    word_t   operandA;
    word_t   aluResult;
    word_t   pc;
    word_t   writeData;

    cpuController controller (.*);

    registerFile regFile (
        .Clock(Clock), .rstN(rstN),
        .writeEnable(regWrite), .writeIdx(writeIdx), .writeData(writeData),
        .readIdxA(readIdxA), .readIdxB(readIdxB),
        .readA(readA), .readB(readB)
    );

    alu brain (.a(operandA), .b(readB), .op(aluOp), .result(aluResult), .flags(aluFlags));

    programCounter pcReg (
        .Clock(Clock), .rstN(rstN),
        .increment(pcIncrement), .branch(pcBranch), .displacement(instr[7:0]),
        .jump(pcJump), .target(aluResult), .pc(pc)
    );

    ////////////////////////////////////////////////////////////
    // Instruction, status and display registers
    ////////////////////////////////////////////////////////////

    // Zeroed on every clock while reset is held
    loadReg #(.payload_t(word_t)) instrReg (
        .Clock(Clock), .rstN(1'b1), .clear(!rstN),
        .enable(irLoad), .d(memData), .q(instr)
    );

    loadReg #(.payload_t(psr_t)) psrReg (
        .Clock(Clock), .rstN(rstN), .clear(1'b0),
        .enable(psrLoad), .d(aluFlags), .q(flags)
    );

    loadReg #(.payload_t(word_t)) vgaStartReg (
        .Clock(Clock), .rstN(rstN), .clear(1'b0),
        .enable(vgaStartLoad), .d(aluResult), .q(vgaStart)
    );

    loadReg #(.payload_t(word_t)) vgaRowReg (
        .Clock(Clock), .rstN(rstN), .clear(1'b0),
        .enable(vgaRowLoad), .d(aluResult), .q(vgaRow)
    );

    ////////////////////////////////////////////////////////////
    // Datapath selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (aluSrc)
            srcReg:  operandA = readA;
            srcImm:  operandA = immediate;
            srcMem:  operandA = memData;
            default: operandA = pc;
        endcase
    end

    // Memory cycle addresses through the source register
    assign memAddr = addrFromReg ? readA : pc;
    assign dataOut = addrFromReg ? readB : aluResult;

    // Write-back from ALU, memory, link, serial or gamepad
    always_comb begin
        if (!regWriteSel) begin
            writeData = aluResult;
        end else if (addrFromReg) begin
            writeData = memData;
        end else if (pcJump) begin
            writeData = pc + word_t'(1);
        end else if (inputSel == ioSerialIn) begin
            writeData = serialRead;
        end else begin
            writeData = {{(wordWidth-8){1'b0}}, gamePad};
        end
    end

endmodule

//--- rtl/cpuController.sv
module cpuController import cpuPkg::*; (
    input  logic    Clock,
    input  logic    rstN,
    input  word_t   instr,
    input  psr_t    flags,
    input  logic    serialValid,
    output logic    regWrite,
    output logic    regWriteSel,
    output regIdx_t writeIdx,
    output regIdx_t readIdxA,
    output regIdx_t readIdxB,
    output word_t   immediate,
    output aluSrc_t aluSrc,
    output aluOp_t  aluOp,
    output logic    addrFromReg,
    output logic    memWrite,
    output logic    pcIncrement,
    output logic    pcBranch,
    output logic    pcJump,
    output logic    irLoad,
    output logic    psrLoad,
    output logic    vgaStartLoad,
    output logic    vgaRowLoad,
    output logic    serialWrite,
    output ioExt_t  inputSel
);

    ctrlState_t state;
    ctrlState_t nextState;
    opcode_t    opcode;
    memExt_t    memExt;
    logic       isImmediate;
    logic       condTrue;
    logic       flagWriter;

    ////////////////////////////////////////////////////////////
    // Field decode
    ////////////////////////////////////////////////////////////

    assign opcode   = opcode_t'(instr[15:12]);
    assign memExt   = memExt_t'(instr[7:4]);
    assign inputSel = ioExt_t'(instr[7:4]);

    assign writeIdx = regIdx_t'(instr[11:8]);
    assign readIdxB = regIdx_t'(instr[11:8]);
    assign readIdxA = regIdx_t'(instr[3:0]);

    assign isImmediate = opcode inside {opAddi, opSubi, opAndi, opOri,
                                        opXori, opMovi, opCmpi, opLshi};
    assign aluSrc      = isImmediate ? srcImm : srcReg;
    assign addrFromReg = (state == stMemory);

    // Logic immediates are zero-extended, the rest sign-extended
    always_comb begin
        if (opcode inside {opAndi, opOri, opXori}) begin
            immediate = {{(wordWidth-8){1'b0}}, instr[7:0]};
        end else begin
            immediate = {{(wordWidth-8){instr[7]}}, instr[7:0]};
        end
    end

    // Jumps, IO and moves pass operand A straight through
    always_comb begin
        case (opcode)
            opRType: aluOp = aluOp_t'(instr[7:4]);
            opAddi:  aluOp = extAdd;
            opSubi:  aluOp = extSub;
            opAndi:  aluOp = extAnd;
            opOri:   aluOp = extOr;
            opXori:  aluOp = extXor;
            opCmpi:  aluOp = extCmp;
            opLshi:  aluOp = extLsh;
            default: aluOp = extMov;
        endcase
    end

    assign flagWriter = aluOp inside {extAdd, extSub, extCmp, extLsh};

    always_comb begin
        case (cond_t'(instr[11:8]))
            condEq:     condTrue = flags.zero;
            condNe:     condTrue = !flags.zero;
            condLt:     condTrue = flags.negative;
            condGe:     condTrue = !flags.negative;
            condLo:     condTrue = flags.low;
            condAlways: condTrue = 1'b1;
            default:    condTrue = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState    = state;
        regWrite     = 1'b0;
        regWriteSel  = 1'b0;
        memWrite     = 1'b0;
        pcIncrement  = 1'b0;
        pcBranch     = 1'b0;
        pcJump       = 1'b0;
        irLoad       = 1'b0;
        psrLoad      = 1'b0;
        vgaStartLoad = 1'b0;
        vgaRowLoad   = 1'b0;
        serialWrite  = 1'b0;
        case (state)
            stFetch: begin
                irLoad    = 1'b1;
                nextState = stExecute;
            end
            stExecute: begin
                nextState   = stFetch;
                pcIncrement = 1'b1;
                psrLoad     = flagWriter;
                case (opcode)
                    opRType, opAddi, opSubi, opAndi, opOri, opXori, opMovi, opCmpi,
                    opLshi: begin
                        regWrite = (aluOp != extCmp);
                    end
                    opMem: begin
                        // PC moves on at the end of the memory cycle
                        pcIncrement = 1'b0;
                        nextState   = stMemory;
                    end
                    opBcond: begin
                        pcBranch    = condTrue;
                        pcIncrement = !condTrue;
                    end
                    opJal: begin
                        regWrite    = 1'b1;
                        regWriteSel = 1'b1;
                        pcJump      = 1'b1;
                    end
                    opIo: begin
                        case (inputSel)
                            ioGamePad: begin
                                regWrite    = 1'b1;
                                regWriteSel = 1'b1;
                            end
                            ioSerialIn: begin
                                // Hold here until the receiver has a word
                                regWrite    = serialValid;
                                regWriteSel = 1'b1;
                                pcIncrement = serialValid;
                                if (!serialValid) begin
                                    nextState = stExecute;
                                end
                            end
                            ioSerialOut: serialWrite  = 1'b1;
                            ioVgaStart:  vgaStartLoad = 1'b1;
                            ioVgaRow:    vgaRowLoad   = 1'b1;
                            default:     serialWrite  = 1'b0;
                        endcase
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            stMemory: begin
                nextState   = stFetch;
                pcIncrement = 1'b1;
                if (memExt == extStore) begin
                    memWrite = 1'b1;
                end else if (memExt == extLoad) begin
                    regWrite    = 1'b1;
                    regWriteSel = 1'b1;
                end
            end
            default: nextState = stFetch;
        endcase
    end

endmodule

//--- rtl/cpuPkg.sv
package cpuPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int wordWidth   = 16;
    localparam int regCount    = 16;
    localparam int regIdxWidth = $clog2(regCount);
    // Opcode, condition and extension fields are one nibble each
    localparam int fieldWidth  = 4;

    typedef logic [wordWidth-1:0]   word_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // Instruction bits 15..12
    typedef enum logic [fieldWidth-1:0] {
        opRType = 4'h0,
        opAddi  = 4'h1,
        opSubi  = 4'h2,
        opAndi  = 4'h3,
        opOri   = 4'h4,
        opXori  = 4'h5,
        opMovi  = 4'h6,
        opCmpi  = 4'h7,
        opLshi  = 4'h8,
        opMem   = 4'h9,
        opBcond = 4'hA,
        opJal   = 4'hB,
        opIo    = 4'hC
    } opcode_t;

    // Extension field of register-register forms
    typedef enum logic [fieldWidth-1:0] {
        extAdd = 4'h0,
        extSub = 4'h1,
        extAnd = 4'h2,
        extOr  = 4'h3,
        extXor = 4'h4,
        extMov = 4'h5,
        extCmp = 4'h6,
        extLsh = 4'h7
    } aluOp_t;

    typedef enum logic [fieldWidth-1:0] {
        extLoad  = 4'h0,
        extStore = 4'h1
    } memExt_t;

    typedef enum logic [fieldWidth-1:0] {
        ioGamePad   = 4'h0,
        ioSerialIn  = 4'h1,
        ioSerialOut = 4'h2,
        ioVgaStart  = 4'h3,
        ioVgaRow    = 4'h4
    } ioExt_t;

    // Branch conditions sit in the destination field
    typedef enum logic [fieldWidth-1:0] {
        condEq     = 4'h0,
        condNe     = 4'h1,
        condLt     = 4'h2,
        condGe     = 4'h3,
        condLo     = 4'h4,
        condAlways = 4'hE
    } cond_t;

    ////////////////////////////////////////////////////////////
    // Processor status and control
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic carry;
        logic low;
        logic flag;
        logic zero;
        logic negative;
    } psr_t;

    typedef enum logic [1:0] {
        stFetch   = 2'd0,
        stExecute = 2'd1,
        stMemory  = 2'd2
    } ctrlState_t;

    typedef enum logic [1:0] {
        srcReg = 2'd0,
        srcImm = 2'd1,
        srcMem = 2'd2,
        srcPc  = 2'd3
    } aluSrc_t;

endpackage

//--- rtl/loadReg.sv
module loadReg import cpuPkg::*; #(
    parameter type payload_t = word_t
) (
    input  logic     Clock,
    input  logic     rstN,
    input  logic     clear,
    input  logic     enable,
    input  payload_t d,
    output payload_t q
);

    // Clear wins over a load in the same cycle
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

//--- rtl/programCounter.sv
module programCounter import cpuPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  logic       increment,
    input  logic       branch,
    input  logic [7:0] displacement,
    input  logic       jump,
    input  word_t      target,
    output word_t      pc
);

    word_t offset;

    // Displacement counts words, relative to the next instruction
    assign offset = {{(wordWidth-8){displacement[7]}}, displacement};

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (jump) begin
            pc <= target;
        end else if (branch) begin
            pc <= pc + offset + word_t'(1);
        end else if (increment) begin
            pc <= pc + word_t'(1);
        end
    end

endmodule

//--- rtl/registerFile.sv
module registerFile import cpuPkg::*; (
    input  logic    Clock,
    input  logic    rstN,
    input  logic    writeEnable,
    input  regIdx_t writeIdx,
    input  regIdx_t readIdxA,
    input  regIdx_t readIdxB,
    input  word_t   writeData,
    output word_t   readA,
    output word_t   readB
);

    word_t regs [regCount];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeIdx] <= writeData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Combinational, so a value written this cycle shows up next cycle
    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];

endmodule

//--- tb/cpuChecks_sva.sv
module cpuChecks import cpuPkg::*; (
    input logic  Clock,
    input logic  rstN,
    input word_t memAddr,
    input word_t dataOut,
    input logic  memWrite,
    input logic  serialWrite
);

    int failures = 0;

    ////////////////////////////////////////////////////////////
    // Strobes
    ////////////////////////////////////////////////////////////

    quietInReset: assert property (@(posedge Clock) !rstN |-> (!memWrite && !serialWrite))
        else begin
            failures++;
            $error("memWrite or serialWrite high while reset is held");
        end

    // Serial-out is a single execute cycle
    serialPulse: assert property (@(posedge Clock) disable iff (!rstN)
        serialWrite |=> !serialWrite)
        else begin
            failures++;
            $error("serialWrite held for more than one cycle");
        end

    memWritePulse: assert property (@(posedge Clock) disable iff (!rstN)
        memWrite |=> !memWrite)
        else begin
            failures++;
            $error("memWrite high on two consecutive cycles");
        end

    portKnown: assert property (@(posedge Clock) disable iff (!rstN)
        memWrite |-> !$isunknown({memAddr, dataOut}))
        else begin
            failures++;
            $error("unknown address or data on a memory write");
        end

endmodule

bind cpu cpuChecks checks (
    .Clock(Clock), .rstN(rstN), .memAddr(memAddr), .dataOut(dataOut),
    .memWrite(memWrite), .serialWrite(serialWrite)
);

//--- tb/cpuTb.sv
module cpuTb import cpuPkg::*; ();

    localparam int period      = 8;
    localparam int progLen     = 78;
    localparam int storeCount  = 12;
    localparam int serialCount = 2;
    localparam int outCount    = 2;
    localparam int vgaCount    = 2;
    localparam int memWords    = 256;

    ////////////////////////////////////////////////////////////
    // Program and expected results
    ////////////////////////////////////////////////////////////

    localparam word_t programWords [progLen] = '{
        16'h6135, 16'h62F0, 16'h110B, 16'h0201, // 00 r1=0040 r2=0030
        16'h2250, 16'h6F60, 16'h911F, 16'h6F61, // 04 r2=FFE0, store r1
        16'h921F, 16'h32F3, 16'h420F, 16'h52FF, // 08 store r2, andi ori xori
        16'h8203, 16'h6F62, 16'h921F, 16'h8212, // 0C lshi left, store, lshi right
        16'h635A, 16'h0311, 16'h0332, 16'h0341, // 10 r3 sub, or, xor
        16'h6F63, 16'h931F, 16'h6404, 16'h0322, // 14 store r3, r4=4, and
        16'h0374, 16'h0553, 16'h6F64, 16'h951F, // 18 lsh, mov, store r5
        16'h67F0, 16'h7404, 16'h6F65, 16'hA001, // 1C r7=FFF0, cmpi r4 equal, beq
        16'hAE01, 16'h911F, 16'h6F66, 16'hA101, // 20 marker, bne
        16'hAE01, 16'h911F, 16'h0267, 16'h6F67, // 24 cmp r2,r7
        16'hA201, 16'hAE01, 16'h911F, 16'h6F68, // 28 blt
        16'hA401, 16'hAE01, 16'h911F, 16'h0762, // 2C blo, cmp r7,r2
        16'h6F69, 16'hA201, 16'hAE01, 16'h911F, // 30 blt
        16'h6F70, 16'h980F, 16'h1811, 16'h981F, // 34 load, addi, store back
        16'h693B, 16'hBA09, 16'h901F, 16'h6F71, // 38 jal r10 over a stray store
        16'h9A1F, 16'hCB10, 16'hCD10, 16'h6F72, // 3C store link, two serial-ins
        16'h9B1F, 16'hCC00, 16'h6F73, 16'h9C1F, // 40 store serial, gamepad
        16'h0B0D, 16'hC02B, 16'hC028, 16'h6E30, // 44 add, two serial-outs
        16'hC03E, 16'hC041, 16'h6E7C, 16'hC03E, // 48 display registers
        16'hC04F, 16'hAEFF                      // 4C last row set, halt loop
    };

    // Address in the upper half, stored word in the lower half
    localparam logic [31:0] storeTable [storeCount] = '{
        32'h0060_0040,
        32'h0061_FFE0,
        32'h0062_0080,
        32'h0063_007A,
        32'h0064_0200,
        32'h0065_0040, // beq taken
        32'h0068_0040, // blo taken
        32'h0069_0040, // blt taken after the swap
        32'h0070_2A81, // fill word of 0x70 plus 0x11
        32'h0071_003A, // link of the jal at 0x39
        32'h0072_C3A5,
        32'h0073_0096
    };

    localparam word_t serialWords [serialCount] = '{16'hC3A5, 16'h1F0E};
    // Sum of both serial words, then the reloaded table word
    localparam word_t outTable [outCount]      = '{16'hE2B3, 16'h2A81};
    localparam word_t startTable [vgaCount]    = '{16'h0030, 16'h007C};
    localparam word_t rowTable [vgaCount]      = '{16'h0040, 16'h0073};

    logic       Clock;
    logic       rstN;
    word_t      memData;
    logic       serialValid;
    word_t      serialRead;
    logic [7:0] gamePad;
    word_t      memAddr;
    logic       memWrite;
    word_t      dataOut;
    word_t      vgaStart;
    word_t      vgaRow;
    logic       serialWrite;

    word_t mem [memWords];
    word_t serialAddr [$];
    int    serialDelay [serialCount];
    int    cycleLimit = 0;
    int    errors = 0;
    int    storeIdx = 0;
    int    outIdx = 0;
    int    startIdx = 0;
    int    rowIdx = 0;
    word_t lastStart = '0;
    word_t lastRow = '0;

    ////////////////////////////////////////////////////////////
    // DUT, clock and memory
    ////////////////////////////////////////////////////////////

    cpu cpu_inst (
        .Clock(Clock), .rstN(rstN), .memData(memData),
        .serialValid(serialValid), .serialRead(serialRead), .gamePad(gamePad),
        .memAddr(memAddr), .memWrite(memWrite), .dataOut(dataOut),
        .vgaStart(vgaStart), .vgaRow(vgaRow), .serialWrite(serialWrite)
    );

    initial Clock = 1'b0;
    always #(period / 2) Clock = ~Clock;

    assign memData = mem[memAddr[7:0]];

    always @(posedge Clock) begin
        if (memWrite) begin
            mem[memAddr[7:0]] <= dataOut;
        end
    end

    function automatic word_t fillWord(input int addr);
        return {8'(addr) ^ 8'h5A, 8'(addr)};
    endfunction

    task automatic reportValue(input string name, input word_t expected, input word_t actual);
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic reportProblem(input string what);
        $display("Error at t=%0t: %s", $time, what);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitors, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge Clock) begin
        if (memWrite) begin
            if (storeIdx >= storeCount) begin
                reportProblem($sformatf("extra store of %h to %h", dataOut, memAddr));
            end else begin
                if (memAddr !== storeTable[storeIdx][31:16]) begin
                    reportValue("memAddr", storeTable[storeIdx][31:16], memAddr);
                end
                if (dataOut !== storeTable[storeIdx][15:0]) begin
                    reportValue("dataOut", storeTable[storeIdx][15:0], dataOut);
                end
                storeIdx++;
            end
        end
        if (serialWrite) begin
            if (outIdx >= outCount) begin
                reportProblem($sformatf("extra serial word %h", dataOut));
            end else begin
                if (dataOut !== outTable[outIdx]) begin
                    reportValue("dataOut", outTable[outIdx], dataOut);
                end
                outIdx++;
            end
        end
        // Display registers may only move to the next table value
        if (vgaStart !== lastStart) begin
            if (startIdx >= vgaCount) begin
                reportProblem($sformatf("vgaStart changed to %h", vgaStart));
            end else begin
                if (vgaStart !== startTable[startIdx]) begin
                    reportValue("vgaStart", startTable[startIdx], vgaStart);
                end
                startIdx++;
            end
            lastStart = vgaStart;
        end
        if (vgaRow !== lastRow) begin
            if (rowIdx >= vgaCount) begin
                reportProblem($sformatf("vgaRow changed to %h", vgaRow));
            end else begin
                if (vgaRow !== rowTable[rowIdx]) begin
                    reportValue("vgaRow", rowTable[rowIdx], vgaRow);
                end
                rowIdx++;
            end
            lastRow = vgaRow;
        end
    end

    ////////////////////////////////////////////////////////////
    // Serial receiver model
    ////////////////////////////////////////////////////////////

    // Valid rises some cycles after the serial-in is fetched
    initial begin : serialDriver
        int k;
        wait (rstN === 1'b1);
        for (k = 0; k < serialCount; k++) begin
            while (memAddr !== serialAddr[k]) @(negedge Clock);
            repeat (serialDelay[k]) @(negedge Clock);
            serialRead  = serialWords[k];
            serialValid = 1'b1;
            @(negedge Clock);
            while (memAddr === serialAddr[k]) @(negedge Clock);
            serialValid = 1'b0;
        end
    end

    initial begin : watchdog
        wait (cycleLimit > 0);
        repeat (cycleLimit) @(posedge Clock);
        $display("Timeout: the CPU did not reach its halt loop within %0d cycles", cycleLimit);
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : mainFlow
        int totalDelay;
        rstN        = 1'b0;
        serialValid = 1'b0;
        serialRead  = '0;
        gamePad     = 8'h96;
        void'($urandom(32'h55fe_d8d1));
        totalDelay = 0;
        for (int k = 0; k < serialCount; k++) begin
            serialDelay[k] = 1 + ($urandom % 8);
            totalDelay += serialDelay[k];
        end
        for (int i = 0; i < memWords; i++) begin
            mem[i] = fillWord(i);
        end
        for (int i = 0; i < progLen; i++) begin
            mem[i] = programWords[i];
            if (programWords[i][15:12] == opIo && programWords[i][7:4] == ioSerialIn) begin
                serialAddr.push_back(word_t'(i));
            end
        end
        // Three cycles per instruction at most, plus the serial waits
        cycleLimit = progLen * 3 + totalDelay + 40;

        repeat (3) @(negedge Clock);
        if (memWrite !== 1'b0) begin
            reportValue("memWrite", '0, word_t'(memWrite));
        end
        if (serialWrite !== 1'b0) begin
            reportValue("serialWrite", '0, word_t'(serialWrite));
        end
        if (vgaStart !== '0) begin
            reportValue("vgaStart", '0, vgaStart);
        end
        if (vgaRow !== '0) begin
            reportValue("vgaRow", '0, vgaRow);
        end
        rstN = 1'b1;
        @(negedge Clock);
        if (memAddr !== '0) begin
            reportValue("memAddr", '0, memAddr);
        end

        // The last word branches onto itself
        while (memAddr !== word_t'(progLen - 1)) @(negedge Clock);
        repeat (2) @(negedge Clock);

        if (storeIdx != storeCount) begin
            reportProblem($sformatf("%0d of %0d stores seen", storeIdx, storeCount));
        end
        if (outIdx != outCount) begin
            reportProblem($sformatf("%0d of %0d serial words sent", outIdx, outCount));
        end
        if (startIdx != vgaCount || rowIdx != vgaCount) begin
            reportProblem($sformatf("display updates %0d/%0d", startIdx, rowIdx));
        end
        errors += cpu_inst.checks.failures;
        $display("Summary: %0d errors, %0d stores, %0d serial words, %0d display updates",
                 errors, storeIdx, outIdx, startIdx + rowIdx);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
